// File: verilog/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

`default_nettype none

// data and address width
`define RV_XLEN         32

// architectural registers, x0 included
`define RV_REG_COUNT    32

// first fetch after reset
`define RV_RESET_ADDR   32'h0000_0000

`default_nettype wire

`endif

// File: verilog/rv_pkg.sv
`include "rv_config.svh"

`default_nettype none

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

    // major opcodes, low two bits always 2'b11
    typedef enum logic [6:0]
    {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // compares return their flag in bit zero
    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_EQ,
        ALU_NE,
        ALU_GE,
        ALU_GEU
    } alu_op_e;

    typedef enum logic [1:0]
    {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_src_e;

    typedef struct packed
    {
        alu_op_e  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    imm;
        logic     op1_pc;
        logic     op2_imm;
        logic     reg_write;
        wb_src_e  wb_src;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     is_jal;
        logic     is_jalr;
        logic     illegal;
    } decoded_t;

    // outgoing wishbone signals
    typedef struct packed
    {
        xlen_t       adr;
        xlen_t       dat;
        logic [3:0]  sel;
        logic        we;
        logic        stb;
        logic        cyc;
    } wb_req_t;

endpackage

`default_nettype wire

// File: verilog/rv_alu.sv
`default_nettype none

module rv_alu
(
    input  wire rv_pkg::xlen_t     i_a,
    input  wire rv_pkg::xlen_t     i_b,
    input  wire rv_pkg::alu_op_e   i_op,
    output rv_pkg::xlen_t          o_result
);

    import rv_pkg::*;

    localparam int SHAMT_W = $clog2($bits(xlen_t));

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    assign shamt = i_b[SHAMT_W-1:0];
    assign lt_s = ($signed(i_a) < $signed(i_b));
    assign lt_u = (i_a < i_b);

    always_comb
    begin
        case (i_op)
        ALU_ADD:  o_result = i_a + i_b;
        ALU_SUB:  o_result = i_a - i_b;
        ALU_SLL:  o_result = i_a << shamt;
        ALU_SLT:  o_result = xlen_t'(lt_s);
        ALU_SLTU: o_result = xlen_t'(lt_u);
        ALU_XOR:  o_result = i_a ^ i_b;
        ALU_SRL:  o_result = i_a >> shamt;
        ALU_SRA:  o_result = xlen_t'($signed(i_a) >>> shamt);
        ALU_OR:   o_result = i_a | i_b;
        ALU_AND:  o_result = i_a & i_b;
        // branch compares
        ALU_EQ:   o_result = xlen_t'(i_a == i_b);
        ALU_NE:   o_result = xlen_t'(i_a != i_b);
        ALU_GE:   o_result = xlen_t'(!lt_s);
        ALU_GEU:  o_result = xlen_t'(!lt_u);
        default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_decoder.sv
`default_nettype none

module rv_decoder
(
    input  wire rv_pkg::xlen_t     i_instr,
    output rv_pkg::decoded_t       o_dec
);

    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign opcode = opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb
    begin
        o_dec = '0;
        o_dec.alu_op = ALU_ADD;
        o_dec.wb_src = WB_ALU;
        o_dec.rs1 = i_instr[19:15];
        o_dec.rs2 = i_instr[24:20];
        o_dec.rd = i_instr[11:7];
        o_dec.imm = imm_i;

        case (opcode)
        OPC_LOAD:
        begin
            // word loads only
            o_dec.illegal = (funct3 != 3'b010);
            o_dec.is_load = 1'b1;
            o_dec.reg_write = 1'b1;
            o_dec.op2_imm = 1'b1;
            o_dec.wb_src = WB_MEM;
        end
        OPC_STORE:
        begin
            o_dec.illegal = (funct3 != 3'b010);
            o_dec.is_store = 1'b1;
            o_dec.op2_imm = 1'b1;
            o_dec.imm = imm_s;
        end
        OPC_OP_IMM:
        begin
            o_dec.reg_write = 1'b1;
            o_dec.op2_imm = 1'b1;
            case (funct3)
            3'b000: o_dec.alu_op = ALU_ADD;
            3'b001:
            begin
                o_dec.alu_op = ALU_SLL;
                o_dec.illegal = (funct7 != 7'b0000000);
            end
            3'b010: o_dec.alu_op = ALU_SLT;
            3'b011: o_dec.alu_op = ALU_SLTU;
            3'b100: o_dec.alu_op = ALU_XOR;
            3'b101:
            begin
                o_dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                o_dec.illegal = ((funct7 & 7'b1011111) != 7'b0000000);
            end
            3'b110: o_dec.alu_op = ALU_OR;
            default: o_dec.alu_op = ALU_AND;
            endcase
        end
        OPC_OP:
        begin
            o_dec.reg_write = 1'b1;
            o_dec.illegal = ((funct7 & 7'b1011111) != 7'b0000000);
            case ({funct7[5], funct3})
            4'b0_000: o_dec.alu_op = ALU_ADD;
            4'b1_000: o_dec.alu_op = ALU_SUB;
            4'b0_001: o_dec.alu_op = ALU_SLL;
            4'b0_010: o_dec.alu_op = ALU_SLT;
            4'b0_011: o_dec.alu_op = ALU_SLTU;
            4'b0_100: o_dec.alu_op = ALU_XOR;
            4'b0_101: o_dec.alu_op = ALU_SRL;
            4'b1_101: o_dec.alu_op = ALU_SRA;
            4'b0_110: o_dec.alu_op = ALU_OR;
            4'b0_111: o_dec.alu_op = ALU_AND;
            default:  o_dec.illegal = 1'b1;
            endcase
        end
        OPC_LUI:
        begin
            // x0 as first operand, so the alu passes the immediate
            o_dec.rs1 = '0;
            o_dec.reg_write = 1'b1;
            o_dec.op2_imm = 1'b1;
            o_dec.imm = imm_u;
        end
        OPC_AUIPC:
        begin
            o_dec.reg_write = 1'b1;
            o_dec.op1_pc = 1'b1;
            o_dec.op2_imm = 1'b1;
            o_dec.imm = imm_u;
        end
        OPC_BRANCH:
        begin
            o_dec.is_branch = 1'b1;
            o_dec.imm = imm_b;
            case (funct3)
            3'b000: o_dec.alu_op = ALU_EQ;
            3'b001: o_dec.alu_op = ALU_NE;
            3'b100: o_dec.alu_op = ALU_SLT;
            3'b101: o_dec.alu_op = ALU_GE;
            3'b110: o_dec.alu_op = ALU_SLTU;
            3'b111: o_dec.alu_op = ALU_GEU;
            default: o_dec.illegal = 1'b1;
            endcase
        end
        OPC_JALR:
        begin
            o_dec.illegal = (funct3 != 3'b000);
            o_dec.is_jalr = 1'b1;
            o_dec.reg_write = 1'b1;
            o_dec.op2_imm = 1'b1;
            o_dec.wb_src = WB_PC4;
        end
        OPC_JAL:
        begin
            o_dec.is_jal = 1'b1;
            o_dec.reg_write = 1'b1;
            o_dec.op1_pc = 1'b1;
            o_dec.op2_imm = 1'b1;
            o_dec.imm = imm_j;
            o_dec.wb_src = WB_PC4;
        end
        default: o_dec.illegal = 1'b1;
        endcase

        // illegal encodings fall through as a plain pc + 4
        if (o_dec.illegal)
        begin
            o_dec.reg_write = 1'b0;
            o_dec.is_load = 1'b0;
            o_dec.is_store = 1'b0;
            o_dec.is_branch = 1'b0;
            o_dec.is_jal = 1'b0;
            o_dec.is_jalr = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`include "rv_config.svh"

`default_nettype none

module rv_regfile
(
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    input  wire rv_pkg::reg_idx_t   i_rs1,
    input  wire rv_pkg::reg_idx_t   i_rs2,
    input  wire rv_pkg::reg_idx_t   i_rd,
    input  wire                     i_we,
    input  wire rv_pkg::xlen_t      i_data,
    output rv_pkg::xlen_t           o_rs1_data,
    output rv_pkg::xlen_t           o_rs2_data
);

    import rv_pkg::*;

    xlen_t regs [`RV_REG_COUNT];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (i_we && (i_rd != '0))
        begin
            regs[i_rd] <= i_data;
        end
    end

    // x0 stays zero from reset on
    assign o_rs1_data = regs[i_rs1];
    assign o_rs2_data = regs[i_rs2];

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`default_nettype none

module rv_execute
(
    input  wire                     i_clk,
    input  wire rv_pkg::decoded_t   i_dec,
    input  wire rv_pkg::xlen_t      i_pc,
    input  wire rv_pkg::xlen_t      i_rs1_data,
    input  wire rv_pkg::xlen_t      i_rs2_data,
    input  wire rv_pkg::xlen_t      i_wb_dat,
    input  wire                     i_exec_en,
    input  wire                     i_load_en,
    output rv_pkg::xlen_t           o_result,
    output rv_pkg::xlen_t           o_store_data,
    output rv_pkg::xlen_t           o_next_pc,
    output rv_pkg::xlen_t           o_wb_data
);

    import rv_pkg::*;

    xlen_t  op_a;
    xlen_t  op_b;
    xlen_t  alu_result;
    xlen_t  pc_plus4;
    xlen_t  target;
    logic   take;
    xlen_t  result_q;
    xlen_t  store_data_q;
    xlen_t  next_pc_q;
    xlen_t  load_q;

    assign op_a = i_dec.op1_pc ? i_pc : i_rs1_data;
    assign op_b = i_dec.op2_imm ? i_dec.imm : i_rs2_data;

    rv_alu alu_i
    (
        .i_a        (op_a),
        .i_b        (op_b),
        .i_op       (i_dec.alu_op),
        .o_result   (alu_result)
    );

    assign pc_plus4 = i_pc + xlen_t'(4);

    // jalr target comes from the alu, branch and jal are pc relative
    assign target = i_dec.is_jalr ? {alu_result[$bits(xlen_t)-1:1], 1'b0}
                                  : i_pc + i_dec.imm;
    assign take = i_dec.is_jal | i_dec.is_jalr | (i_dec.is_branch & alu_result[0]);

    always_ff @(posedge i_clk)
    begin
        if (i_exec_en)
        begin
            result_q <= alu_result;
            store_data_q <= i_rs2_data;
            next_pc_q <= take ? target : pc_plus4;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_load_en)
            load_q <= i_wb_dat;
    end

    assign o_result = result_q;
    assign o_store_data = store_data_q;
    assign o_next_pc = next_pc_q;

    // pc is still the current instruction's during write-back
    always_comb
    begin
        case (i_dec.wb_src)
        WB_MEM:  o_wb_data = load_q;
        WB_PC4:  o_wb_data = pc_plus4;
        default: o_wb_data = result_q;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_control.sv
`include "rv_config.svh"

`default_nettype none

module rv_control
(
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    input  wire rv_pkg::xlen_t      i_wb_dat,
    input  wire                     i_wb_ack,
    input  wire rv_pkg::decoded_t   i_dec,
    input  wire rv_pkg::xlen_t      i_result,
    input  wire rv_pkg::xlen_t      i_store_data,
    input  wire rv_pkg::xlen_t      i_next_pc,
    output rv_pkg::wb_req_t         o_wb_req,
    output rv_pkg::xlen_t           o_instr,
    output rv_pkg::xlen_t           o_pc,
    output logic                    o_exec_en,
    output logic                    o_load_en,
    output logic                    o_reg_we
);

    import rv_pkg::*;

    typedef enum logic [2:0]
    {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEM,
        ST_WRITEBACK
    } state_e;

    state_e state;
    state_e state_nxt;
    xlen_t  pc;
    xlen_t  ir;
    logic   mem_phase;

    always_comb
    begin
        case (state)
        ST_FETCH:     state_nxt = i_wb_ack ? ST_DECODE : ST_FETCH;
        ST_DECODE:    state_nxt = ST_EXECUTE;
        // only loads and stores touch the bus again
        ST_EXECUTE:   state_nxt = (i_dec.is_load | i_dec.is_store) ? ST_MEM : ST_WRITEBACK;
        ST_MEM:       state_nxt = i_wb_ack ? ST_WRITEBACK : ST_MEM;
        default:      state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state <= ST_FETCH;
            pc <= `RV_RESET_ADDR;
        end
        else
        begin
            state <= state_nxt;
            if (state == ST_WRITEBACK)
                pc <= i_next_pc;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if ((state == ST_FETCH) && i_wb_ack)
            ir <= i_wb_dat;
    end

    assign mem_phase = (state == ST_MEM);

    // request held steady until ack, all sources are registered
    assign o_wb_req.adr = mem_phase ? i_result : pc;
    assign o_wb_req.dat = mem_phase ? i_store_data : '0;
    assign o_wb_req.sel = 4'b1111;
    assign o_wb_req.we = mem_phase & i_dec.is_store;
    assign o_wb_req.stb = (state == ST_FETCH) | mem_phase;
    assign o_wb_req.cyc = (state == ST_FETCH) | mem_phase;

    assign o_instr = ir;
    assign o_pc = pc;
    assign o_exec_en = (state == ST_EXECUTE);
    assign o_load_en = mem_phase & i_wb_ack;
    assign o_reg_we = (state == ST_WRITEBACK) & i_dec.reg_write;

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`default_nettype none

module rv_core
(
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    output rv_pkg::wb_req_t         o_wb_req,
    input  wire rv_pkg::xlen_t      i_wb_dat,
    input  wire                     i_wb_ack
);

    import rv_pkg::*;

    xlen_t      instr;
    xlen_t      pc;
    xlen_t      result;
    xlen_t      store_data;
    xlen_t      next_pc;
    xlen_t      wb_data;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    decoded_t   dec;
    logic       exec_en;
    logic       load_en;
    logic       reg_we;

    rv_control control_i
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_wb_dat       (i_wb_dat),
        .i_wb_ack       (i_wb_ack),
        .i_dec          (dec),
        .i_result       (result),
        .i_store_data   (store_data),
        .i_next_pc      (next_pc),
        .o_wb_req       (o_wb_req),
        .o_instr        (instr),
        .o_pc           (pc),
        .o_exec_en      (exec_en),
        .o_load_en      (load_en),
        .o_reg_we       (reg_we)
    );

    rv_decoder decoder_i
    (
        .i_instr        (instr),
        .o_dec          (dec)
    );

    rv_execute execute_i
    (
        .i_clk          (i_clk),
        .i_dec          (dec),
        .i_pc           (pc),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_wb_dat       (i_wb_dat),
        .i_exec_en      (exec_en),
        .i_load_en      (load_en),
        .o_result       (result),
        .o_store_data   (store_data),
        .o_next_pc      (next_pc),
        .o_wb_data      (wb_data)
    );

    rv_regfile regfile_i
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_rs1          (dec.rs1),
        .i_rs2          (dec.rs2),
        .i_rd           (dec.rd),
        .i_we           (reg_we),
        .i_data         (wb_data),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data)
    );

endmodule

`default_nettype wire

// File: bench/tb_wb_memory.sv
`default_nettype none

module tb_wb_memory
#(
    parameter int WORDS = 2048,
    parameter int LOG_DEPTH = 4096,
    parameter int SEED = 1
)
(
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    input  wire rv_pkg::wb_req_t    i_req,
    output rv_pkg::xlen_t           o_dat,
    output logic                    o_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int IDX_W = $clog2(WORDS);

    // loaded by the testbench before reset is released
    xlen_t            mem [WORDS];
    // every completed transfer in bus order
    wb_req_t          log_req [LOG_DEPTH];
    int               log_count;
    integer           seed;
    logic             busy;
    int               delay;
    logic [IDX_W-1:0] idx;

    initial
    begin
        seed = SEED;
        log_count = 0;
        busy = 1'b0;
        delay = 0;
        o_ack = 1'b0;
        o_dat = '0;
        forever
        begin
            @(negedge i_clk);
            o_ack <= 1'b0;
            if (!i_reset_n)
            begin
                busy = 1'b0;
            end
            else
            begin
                // new request, ack after 0 to 3 idle cycles
                if (i_req.cyc && i_req.stb && !busy)
                begin
                    busy = 1'b1;
                    delay = {$random(seed)} % 4;
                end
                if (busy && (delay == 0))
                begin
                    idx = i_req.adr[IDX_W+1:2];
                    if (i_req.we)
                        mem[idx] = i_req.dat;
                    else
                        o_dat <= mem[idx];
                    if (log_count < LOG_DEPTH)
                        log_req[log_count] = i_req;
                    log_count++;
                    busy = 1'b0;
                    o_ack <= 1'b1;
                end
                else if (busy)
                begin
                    delay--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_rv_core.sv
`include "rv_config.svh"

`default_nettype none

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int MEM_WORDS = 2048;
    localparam int DATA_BASE = 1024;
    localparam int DATA_WORDS = 512;
    localparam int BODY_LEN = 300;
    localparam int MAX_STEPS = 4000;
    localparam int TIMEOUT_CYCLES = 100000;

    localparam logic [6:0] LOAD = 7'h03;
    localparam logic [6:0] OP_IMM = 7'h13;
    localparam logic [6:0] AUIPC = 7'h17;
    localparam logic [6:0] STORE = 7'h23;
    localparam logic [6:0] OP_REG = 7'h33;
    localparam logic [6:0] LUI = 7'h37;
    localparam logic [6:0] BRANCH = 7'h63;
    localparam logic [6:0] JALR = 7'h67;
    localparam logic [6:0] JAL = 7'h6f;

    logic    clk;
    logic    reset_n;
    wb_req_t wb_req;
    xlen_t   wb_dat;
    logic    wb_ack;

    integer  seed;
    int      errors;
    int      timeouts;
    int      prog_len;
    xlen_t   halt_pc;
    xlen_t   ref_mem [MEM_WORDS];
    xlen_t   ref_regs [32];
    wb_req_t exp_req [$];
    wb_req_t held_req;
    logic    held_valid;

    rv_core dut_i
    (
        .i_clk      (clk),
        .i_reset_n  (reset_n),
        .o_wb_req   (wb_req),
        .i_wb_dat   (wb_dat),
        .i_wb_ack   (wb_ack)
    );

    tb_wb_memory #(.WORDS(MEM_WORDS), .SEED(32'h28737824)) mem_i
    (
        .i_clk      (clk),
        .i_reset_n  (reset_n),
        .i_req      (wb_req),
        .o_dat      (wb_dat),
        .o_ack      (wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input wb_req_t got, input wb_req_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic int pick(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic xlen_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic xlen_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic xlen_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic xlen_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic xlen_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    // word offset into the data region behind x31
    function automatic logic [11:0] data_off();
        return 12'(pick(DATA_WORDS) * 4);
    endfunction

    function automatic xlen_t illegal_word(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        case (pick(6))
        0: return i_type(data_off(), 5'd31, 3'd0, rd, LOAD);
        1: return s_type(data_off(), rd, 5'd31, 3'd1);
        2: return 32'h0000_0073;
        3: return 32'h0ff0_000f;
        4: return b_type(13'd8, rs2, rs1, 3'd2);
        default: return r_type(7'h20, rs2, rs1, 3'd7, rd);
        endcase
    endfunction

    function automatic wb_req_t bus_xfer(input xlen_t adr, input xlen_t dat, input logic we);
        wb_req_t req;
        req.adr = adr;
        req.dat = dat;
        req.sel = 4'hf;
        req.we = we;
        req.stb = 1'b1;
        req.cyc = 1'b1;
        return req;
    endfunction

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
        endcase
    endfunction

    task automatic place(input xlen_t ins);
        ref_mem[prog_len] = ins;
        prog_len++;
    endtask

    task automatic build_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  link;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          reach;
        for (int w = 0; w < MEM_WORDS; w++)
            ref_mem[w] = $random(seed);
        prog_len = 0;
        reach = 0;
        for (int r = 1; r < 31; r++)
        begin
            place(u_type(20'($random(seed)), 5'(r), LUI));
            place(i_type(12'($random(seed)), 5'(r), 3'd0, 5'(r), OP_IMM));
        end
        place(u_type(20'h00001, 5'd31, LUI));
        for (int n = 0; n < BODY_LEN; n++)
        begin
            rd = 5'(pick(31));
            rs1 = 5'(pick(32));
            rs2 = 5'(pick(32));
            f3 = 3'(pick(8));
            case (pick(10))
            0, 1:
            begin
                f7 = 7'h00;
                if (((f3 == 3'd0) || (f3 == 3'd5)) && (pick(2) == 1))
                    f7 = 7'h20;
                place(r_type(f7, rs2, rs1, f3, rd));
            end
            2, 3:
            begin
                imm = 12'($random(seed));
                if (f3 == 3'd1)
                    imm[11:5] = 7'h00;
                if (f3 == 3'd5)
                    imm[11:5] = (pick(2) == 1) ? 7'h20 : 7'h00;
                place(i_type(imm, rs1, f3, rd, OP_IMM));
            end
            4: place(u_type(20'($random(seed)), rd, (pick(2) == 1) ? LUI : AUIPC));
            5:
            begin
                // the six branch kinds jump 2 to 4 words ahead
                f3 = 3'(pick(6));
                if (f3 >= 3'd2)
                    f3 = f3 + 3'd2;
                reach = prog_len + 4;
                place(b_type(13'((2 + pick(3)) * 4), rs2, rs1, f3));
            end
            6:
            begin
                reach = prog_len + 4;
                place(j_type(21'((1 + pick(4)) * 4), rd));
            end
            7:
            begin
                // nop padding so no earlier jump lands between auipc and jalr
                while (prog_len < reach)
                    place(i_type(12'h0, 5'd0, 3'd0, 5'd0, OP_IMM));
                // odd offsets check that jalr drops bit zero
                link = 5'(1 + pick(30));
                place(u_type(20'h0, link, AUIPC));
                place(i_type(12'(8 + 4 * pick(2) + pick(2)), link, 3'd0, rd, JALR));
            end
            8: place(i_type(data_off(), 5'd31, 3'd2, rd, LOAD));
            default: place(illegal_word(rd, rs1, rs2));
            endcase
            place(s_type(data_off(), rd, 5'd31, 3'd2));
        end
        for (int k = 0; k < 4; k++)
            place(i_type(12'h0, 5'd0, 3'd0, 5'd0, OP_IMM));
        halt_pc = xlen_t'(prog_len * 4);
        place(j_type(21'h0, 5'd0));
    endtask

    // instruction-set model fills exp_req with the bus transfers in order
    task automatic run_model();
        xlen_t      pc;
        xlen_t      ins;
        xlen_t      a;
        xlen_t      b;
        xlen_t      adr;
        xlen_t      val;
        xlen_t      nxt;
        xlen_t      imm_i;
        xlen_t      imm_s;
        xlen_t      imm_b;
        xlen_t      imm_j;
        xlen_t      imm_u;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       legal;
        logic       wr;
        logic       take;
        for (int r = 0; r < 32; r++)
            ref_regs[r] = '0;
        pc = `RV_RESET_ADDR;
        for (int step = 0; step < MAX_STEPS; step++)
        begin
            ins = ref_mem[pc[12:2]];
            exp_req.push_back(bus_xfer(pc, '0, 1'b0));
            if (pc == halt_pc)
                break;
            f3 = ins[14:12];
            f7 = ins[31:25];
            a = ref_regs[ins[19:15]];
            b = ref_regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            imm_u = {ins[31:12], 12'h000};
            legal = 1'b1;
            wr = 1'b1;
            val = '0;
            take = 1'b0;
            nxt = pc + 32'd4;
            case (ins[6:0])
            LUI: val = imm_u;
            AUIPC: val = pc + imm_u;
            JAL:
            begin
                val = pc + 32'd4;
                nxt = pc + imm_j;
            end
            JALR:
            begin
                legal = (f3 == 3'd0);
                val = pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
            end
            BRANCH:
            begin
                wr = 1'b0;
                case (f3)
                3'd0: take = (a == b);
                3'd1: take = (a != b);
                3'd4: take = ($signed(a) < $signed(b));
                3'd5: take = ($signed(a) >= $signed(b));
                3'd6: take = (a < b);
                3'd7: take = (a >= b);
                default: legal = 1'b0;
                endcase
                if (take)
                    nxt = pc + imm_b;
            end
            LOAD:
            begin
                legal = (f3 == 3'd2);
                adr = a + imm_i;
                if (legal)
                begin
                    exp_req.push_back(bus_xfer(adr, '0, 1'b0));
                    val = ref_mem[adr[12:2]];
                end
            end
            STORE:
            begin
                legal = (f3 == 3'd2);
                wr = 1'b0;
                adr = a + imm_s;
                if (legal)
                begin
                    exp_req.push_back(bus_xfer(adr, b, 1'b1));
                    ref_mem[adr[12:2]] = b;
                end
            end
            OP_IMM:
            begin
                if (f3 == 3'd1)
                    legal = (f7 == 7'h00);
                else if (f3 == 3'd5)
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                val = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
            end
            OP_REG:
            begin
                legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
                val = alu_ref(f3, ins[30], a, b);
            end
            default: legal = 1'b0;
            endcase
            // illegal encodings only step the pc
            if (!legal)
                nxt = pc + 32'd4;
            if (legal && wr && (ins[11:7] != 5'd0))
                ref_regs[ins[11:7]] = val;
            pc = nxt;
        end
    endtask

    // a pending request holds every field until its ack
    always @(posedge clk)
    begin
        if (reset_n && wb_req.cyc && wb_req.stb)
        begin
            if (held_valid)
                check_req("o_wb_req while waiting for ack", wb_req, held_req);
            else
                held_req = wb_req;
            held_valid = !wb_ack;
        end
        else
        begin
            held_valid = 1'b0;
        end
    end

    initial
    begin : main
        int      n;
        int      cycles;
        wb_req_t got;
        wb_req_t exp;
        seed = 32'h28737824;
        errors = 0;
        timeouts = 0;
        held_valid = 1'b0;
        reset_n = 1'b0;
        build_program();
        for (int w = 0; w < MEM_WORDS; w++)
            mem_i.mem[w] = ref_mem[w];
        run_model();
        repeat (5) @(negedge clk);
        reset_n <= 1'b1;

        // the last expected transfer is the fetch of the halt loop
        cycles = 0;
        while ((mem_i.log_count < exp_req.size()) && (cycles < TIMEOUT_CYCLES))
        begin
            @(posedge clk);
            cycles++;
        end
        if (mem_i.log_count < exp_req.size())
        begin
            timeouts++;
            $display("timeout after %0d cycles: saw %0d of %0d bus transfers",
                     cycles, mem_i.log_count, exp_req.size());
        end

        n = (mem_i.log_count < exp_req.size()) ? mem_i.log_count : exp_req.size();
        for (int i = 0; i < n; i++)
        begin
            got = mem_i.log_req[i];
            exp = exp_req[i];
            // write data is meaningless on reads
            if (!exp.we)
                got.dat = '0;
            check_req($sformatf("o_wb_req transfer %0d", i), got, exp);
        end
        for (int w = DATA_BASE; w < DATA_BASE + DATA_WORDS; w++)
            check_word($sformatf("memory word %h", w * 4), mem_i.mem[w], ref_mem[w]);

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if ((errors == 0) && (timeouts == 0))
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_control.sv
verilog/rv_core.sv
bench/tb_wb_memory.sv
bench/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/rv_alu.sv
      - verilog/rv_decoder.sv
      - verilog/rv_regfile.sv
      - verilog/rv_execute.sv
      - verilog/rv_control.sv
      - verilog/rv_core.sv
  - target: simulation
    files:
      - bench/tb_wb_memory.sv
      - bench/tb_rv_core.sv
